// File: design/router_cfg_pkg.sv
/* Router geometry and scheduler timing constants
   plus the priority index type */
package router_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // Queue geometry
    ////////////////////////////////////////////////////////////

    // Priority queues behind every egress port
    localparam int QUEUES_PER_PORT = 4;

    // Bits needed to name one queue within its port
    localparam int QUEUE_SEL_W = 2;

    // Upper bound on egress ports, keeps the queue number within the address field
    localparam int MAX_EGR_PORTS = 16;

    ////////////////////////////////////////////////////////////
    // Scheduler timing
    ////////////////////////////////////////////////////////////

    // Cycles a port stays blocked once a request has gone out
    // Must cover the engine's notification delay
    localparam int DQ_LATENCY = 2;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    // Priority of a queue within its port, higher index wins
    typedef logic [QUEUE_SEL_W-1:0] prio_t;

endpackage : router_cfg_pkg

// File: design/pkt_fmt_pkg.sv
/* Packet word, queue entry and occupancy types
   with the Wishbone address field layout */
package pkt_fmt_pkg;

    ////////////////////////////////////////////////////////////
    // Packet words
    ////////////////////////////////////////////////////////////

    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;

    // Stored entry, end-of-packet flag on top of the data word
    typedef logic [WORD_W:0] entry_t;

    ////////////////////////////////////////////////////////////
    // Queue depth and occupancy
    ////////////////////////////////////////////////////////////

    localparam int DEPTH_LOG = 4;
    localparam int QUEUE_DEPTH = 1 << DEPTH_LOG;

    // One extra bit so a full queue is distinct from an empty one
    typedef logic [DEPTH_LOG:0] level_t;

    ////////////////////////////////////////////////////////////
    // Wishbone address layout
    ////////////////////////////////////////////////////////////

    localparam int WB_ADDR_W = 8;

    // Low bits carry the queue number, port above priority
    typedef logic [WB_ADDR_W-1:0] wb_addr_t;

    // Set on the write of a packet's final word
    localparam int LAST_BIT = 7;

endpackage : pkt_fmt_pkg

// File: design/queue_buffer.sv
/* Per-queue circular packet buffers with a Wishbone classic slave
   for enqueue and occupancy read, plus the dequeue pop port */
module queue_buffer #(
    parameter int NUM_EGR_PORTS = 4,
    localparam int NUM_QUEUES = NUM_EGR_PORTS * router_cfg_pkg::QUEUES_PER_PORT,
    localparam int PORT_W = (NUM_EGR_PORTS > 1) ? $clog2(NUM_EGR_PORTS) : 1,
    localparam int QNUM_W = PORT_W + router_cfg_pkg::QUEUE_SEL_W
) (
    input  logic                     dequeue_req,
    input  logic                     arst_n,

    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  pkt_fmt_pkg::wb_addr_t    wb_adr,
    input  pkt_fmt_pkg::word_t       wb_dat_w,
    output pkt_fmt_pkg::word_t       wb_dat_r,
    output logic                     wb_ack,

    input  logic                     pop,
    input  logic [QNUM_W-1:0]        pop_queue,
    output pkt_fmt_pkg::word_t       pop_data,
    output logic                     pop_last,
    output logic [NUM_QUEUES-1:0]    queue_empty
);

    import pkt_fmt_pkg::*;

    ////////////////////////////////////////////////////////////
    // Storage and pointers
    ////////////////////////////////////////////////////////////

    entry_t               mem    [NUM_QUEUES][QUEUE_DEPTH];
    logic [DEPTH_LOG-1:0] wr_ptr [NUM_QUEUES];
    logic [DEPTH_LOG-1:0] rd_ptr [NUM_QUEUES];
    level_t               level  [NUM_QUEUES];

    logic [QNUM_W-1:0]     wb_q;
    logic                  wb_req;
    logic                  q_full;
    logic                  push;
    logic                  rd_hit;
    logic [NUM_QUEUES-1:0] push_vec;
    logic [NUM_QUEUES-1:0] pop_vec;
    entry_t                head;

    ////////////////////////////////////////////////////////////
    // Wishbone decode
    ////////////////////////////////////////////////////////////

    // No new action while the ack of the current cycle is out
    assign wb_req = wb_cyc && wb_stb && !wb_ack;
    assign wb_q   = wb_adr[QNUM_W-1:0];
    assign q_full = (level[wb_q] == level_t'(QUEUE_DEPTH));

    // A full queue holds the write off until a pop frees a slot
    assign push   = wb_req && wb_we && !q_full;
    assign rd_hit = wb_req && !wb_we;

    always_comb begin
        push_vec = '0;
        pop_vec  = '0;
        if (push) begin
            push_vec[wb_q] = 1'b1;
        end
        if (pop) begin
            pop_vec[pop_queue] = 1'b1;
        end
    end

    always_ff @(posedge dequeue_req or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
            wr_ptr <= '{default: '0};
            rd_ptr <= '{default: '0};
            level  <= '{default: '0};
        end else begin
            wb_ack <= push || rd_hit;
            for (int i = 0; i < NUM_QUEUES; i++) begin
                if (push_vec[i]) begin
                    wr_ptr[i] <= wr_ptr[i] + 1'b1;
                end
                if (pop_vec[i]) begin
                    rd_ptr[i] <= rd_ptr[i] + 1'b1;
                end
                level[i] <= level[i] + level_t'(push_vec[i]) - level_t'(pop_vec[i]);
            end
        end
    end

    // Entry write and occupancy readback
    always_ff @(posedge dequeue_req) begin
        if (push) begin
            mem[wb_q][wr_ptr[wb_q]] <= {wb_adr[LAST_BIT], wb_dat_w};
        end
        if (rd_hit) begin
            wb_dat_r <= word_t'(level[wb_q]);
        end
    end

    ////////////////////////////////////////////////////////////
    // Pop side
    ////////////////////////////////////////////////////////////

    assign head     = mem[pop_queue][rd_ptr[pop_queue]];
    assign pop_data = head[WORD_W-1:0];
    assign pop_last = head[WORD_W];

    always_comb begin
        for (int i = 0; i < NUM_QUEUES; i++) begin
            queue_empty[i] = (level[i] == '0);
        end
    end

    // Scheduler must only ask for words that are present
    a_no_pop_empty: assert property (@(posedge dequeue_req) disable iff (!arst_n)
        pop |-> !queue_empty[pop_queue]);

    a_ack_needs_stb: assert property (@(posedge dequeue_req) disable iff (!arst_n)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb));

endmodule : queue_buffer

// File: design/egress_scheduler.sv
/* Round-robin egress port selection with strict-priority,
   packet-locked queue selection that issues dequeue requests */
module egress_scheduler #(
    parameter int NUM_EGR_PORTS = 4,
    localparam int NUM_QUEUES = NUM_EGR_PORTS * router_cfg_pkg::QUEUES_PER_PORT,
    localparam int PORT_W = (NUM_EGR_PORTS > 1) ? $clog2(NUM_EGR_PORTS) : 1,
    localparam int QNUM_W = PORT_W + router_cfg_pkg::QUEUE_SEL_W
) (
    input  logic                  dequeue_req,
    input  logic                  arst_n,
    input  logic [NUM_QUEUES-1:0] queue_empty,

    input  logic                  note_valid,
    input  logic                  note_last,
    input  logic [QNUM_W-1:0]     note_queue,

    output logic                  req_valid,
    output logic [QNUM_W-1:0]     req_queue
);

    import router_cfg_pkg::*;

    typedef logic [PORT_W-1:0] port_t;

    port_t                   port_sel;
    logic                    sel_valid;
    logic [NUM_EGR_PORTS-1:0] locked;
    prio_t                   active_q  [NUM_EGR_PORTS];
    logic [DQ_LATENCY-1:0]   in_flight [NUM_EGR_PORTS];

    logic [NUM_EGR_PORTS-1:0] busy;
    logic [NUM_EGR_PORTS-1:0] eligible;
    logic                    rr_found;
    port_t                   rr_port;
    prio_t                   pick_prio;
    port_t                   note_port;

    ////////////////////////////////////////////////////////////
    // Port eligibility
    ////////////////////////////////////////////////////////////

    // A pending selection counts as busy so the port is not picked twice
    always_comb begin
        logic [QUEUES_PER_PORT-1:0] qe;
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            qe = queue_empty[p*QUEUES_PER_PORT +: QUEUES_PER_PORT];
            busy[p] = (|in_flight[p]) || (sel_valid && (int'(port_sel) == p));
            if (locked[p]) begin
                eligible[p] = !qe[active_q[p]] && !busy[p];
            end else begin
                eligible[p] = !(&qe) && !busy[p];
            end
        end
    end

    // Search starts one past the last port chosen
    always_comb begin
        int cand;
        rr_found = 1'b0;
        rr_port  = port_sel;
        for (int i = 1; i <= NUM_EGR_PORTS; i++) begin
            cand = (int'(port_sel) + i) % NUM_EGR_PORTS;
            if (!rr_found && eligible[cand]) begin
                rr_found = 1'b1;
                rr_port  = port_t'(cand);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Queue pick for an unlocked port
    ////////////////////////////////////////////////////////////

    always_comb begin
        logic [QUEUES_PER_PORT-1:0] sel_empty;
        sel_empty = queue_empty[int'(port_sel)*QUEUES_PER_PORT +: QUEUES_PER_PORT];
        pick_prio = '0;
        // Ascending scan, the last hit is the highest priority
        for (int q = 0; q < QUEUES_PER_PORT; q++) begin
            if (!sel_empty[q]) begin
                pick_prio = prio_t'(q);
            end
        end
    end

    assign note_port = note_queue[QUEUE_SEL_W +: PORT_W];

    always_ff @(posedge dequeue_req or negedge arst_n) begin
        if (!arst_n) begin
            port_sel  <= '0;
            sel_valid <= 1'b0;
            req_valid <= 1'b0;
            req_queue <= '0;
            locked    <= '0;
            active_q  <= '{default: '0};
            in_flight <= '{default: '0};
        end else begin
            sel_valid <= rr_found;
            if (rr_found) begin
                port_sel <= rr_port;
            end
            for (int p = 0; p < NUM_EGR_PORTS; p++) begin
                in_flight[p] <= {in_flight[p][DQ_LATENCY-2:0], 1'b0};
            end
            if (note_valid && note_last) begin
                locked[note_port] <= 1'b0;
            end
            // Request follows the registered selection by one cycle
            req_valid <= sel_valid;
            if (sel_valid) begin
                in_flight[port_sel][0] <= 1'b1;
                if (locked[port_sel]) begin
                    req_queue <= {port_sel, active_q[port_sel]};
                end else begin
                    req_queue          <= {port_sel, pick_prio};
                    active_q[port_sel] <= pick_prio;
                    locked[port_sel]   <= 1'b1;
                end
            end
        end
    end

    a_no_req_in_flight: assert property (@(posedge dequeue_req) disable iff (!arst_n)
        sel_valid |-> (in_flight[port_sel] == '0));

    a_reset_state: assert property (@(posedge dequeue_req)
        !arst_n |-> (!req_valid && !sel_valid && (locked == '0)));

    a_port_limits: assert property (@(posedge dequeue_req)
        (NUM_EGR_PORTS >= 1) && (NUM_EGR_PORTS <= MAX_EGR_PORTS));

endmodule : egress_scheduler

// File: design/dequeue_engine.sv
/* Dequeue engine that pops the requested queue and registers
   the head word onto the output stream and the notification */
module dequeue_engine #(
    parameter int NUM_EGR_PORTS = 4,
    localparam int PORT_W = (NUM_EGR_PORTS > 1) ? $clog2(NUM_EGR_PORTS) : 1,
    localparam int QNUM_W = PORT_W + router_cfg_pkg::QUEUE_SEL_W
) (
    input  logic                  dequeue_req,
    input  logic                  arst_n,

    input  logic                  req_valid,
    input  logic [QNUM_W-1:0]     req_queue,
    input  pkt_fmt_pkg::word_t    pop_data,
    input  logic                  pop_last,

    output logic                  pop,
    output logic [QNUM_W-1:0]     pop_queue,

    output logic                  out_valid,
    output pkt_fmt_pkg::word_t    out_data,
    output logic                  out_last,
    output logic [PORT_W-1:0]     out_port,
    output router_cfg_pkg::prio_t out_queue,

    output logic                  note_valid,
    output logic                  note_last,
    output logic [QNUM_W-1:0]     note_queue
);

    import router_cfg_pkg::*;

    ////////////////////////////////////////////////////////////
    // Pop request
    ////////////////////////////////////////////////////////////

    // Every request is accepted and the head word is read in the same cycle
    assign pop       = req_valid;
    assign pop_queue = req_queue;

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge dequeue_req or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= req_valid;
        end
    end

    always_ff @(posedge dequeue_req) begin
        if (req_valid) begin
            out_data  <= pop_data;
            out_last  <= pop_last;
            out_port  <= req_queue[QUEUE_SEL_W +: PORT_W];
            out_queue <= req_queue[QUEUE_SEL_W-1:0];
        end
    end

    // Notification mirrors the output word
    assign note_valid = out_valid;
    assign note_last  = out_last;
    assign note_queue = {out_port, out_queue};

    a_note_one_cycle: assert property (@(posedge dequeue_req) disable iff (!arst_n)
        req_valid |=> (note_valid && (note_queue == $past(req_queue))));

    // Lock release has to land while the scheduler still blocks the port
    a_note_in_window: assert property (@(posedge dequeue_req) disable iff (!arst_n)
        req_valid |-> ##[1:DQ_LATENCY-1] note_valid);

endmodule : dequeue_engine

// File: design/pkt_egress_top.sv
/* Egress top level joining the queue buffer,
   the scheduler and the dequeue engine */
module pkt_egress_top #(
    parameter int NUM_EGR_PORTS = 4,
    localparam int NUM_QUEUES = NUM_EGR_PORTS * router_cfg_pkg::QUEUES_PER_PORT,
    localparam int PORT_W = (NUM_EGR_PORTS > 1) ? $clog2(NUM_EGR_PORTS) : 1,
    localparam int QNUM_W = PORT_W + router_cfg_pkg::QUEUE_SEL_W
) (
    input  logic                  dequeue_req,
    input  logic                  arst_n,

    // Host write and occupancy read
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  pkt_fmt_pkg::wb_addr_t wb_adr,
    input  pkt_fmt_pkg::word_t    wb_dat_w,
    output pkt_fmt_pkg::word_t    wb_dat_r,
    output logic                  wb_ack,

    // Egress stream toward the MAC
    output logic                  out_valid,
    output pkt_fmt_pkg::word_t    out_data,
    output logic                  out_last,
    output logic [PORT_W-1:0]     out_port,
    output router_cfg_pkg::prio_t out_queue
);

    import pkt_fmt_pkg::*;

    logic [NUM_QUEUES-1:0] queue_empty;
    logic                  req_valid;
    logic [QNUM_W-1:0]     req_queue;
    logic                  pop;
    logic [QNUM_W-1:0]     pop_queue;
    word_t                 pop_data;
    logic                  pop_last;
    logic                  note_valid;
    logic                  note_last;
    logic [QNUM_W-1:0]     note_queue;

    queue_buffer #(.NUM_EGR_PORTS(NUM_EGR_PORTS)) u_queue_buffer (
        .dequeue_req (dequeue_req),
        .arst_n      (arst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .pop         (pop),
        .pop_queue   (pop_queue),
        .pop_data    (pop_data),
        .pop_last    (pop_last),
        .queue_empty (queue_empty)
    );

    egress_scheduler #(.NUM_EGR_PORTS(NUM_EGR_PORTS)) u_egress_scheduler (
        .dequeue_req (dequeue_req),
        .arst_n      (arst_n),
        .queue_empty (queue_empty),
        .note_valid  (note_valid),
        .note_last   (note_last),
        .note_queue  (note_queue),
        .req_valid   (req_valid),
        .req_queue   (req_queue)
    );

    dequeue_engine #(.NUM_EGR_PORTS(NUM_EGR_PORTS)) u_dequeue_engine (
        .dequeue_req (dequeue_req),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req_queue   (req_queue),
        .pop_data    (pop_data),
        .pop_last    (pop_last),
        .pop         (pop),
        .pop_queue   (pop_queue),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_last    (out_last),
        .out_port    (out_port),
        .out_queue   (out_queue),
        .note_valid  (note_valid),
        .note_last   (note_last),
        .note_queue  (note_queue)
    );

endmodule : pkt_egress_top

// File: verification/pkt_egress_ref.svh
/* Expected egress order of one port, LCG stimulus source
   and the value compare behind every check */
`ifndef PKT_EGRESS_REF_SVH
`define PKT_EGRESS_REF_SVH

// One egress word, the port is given by the list that holds it
typedef struct packed {
    prio_t prio;
    logic  last;
    word_t data;
} xword_t;

typedef xword_t xlist_t[$];

int unsigned lcg_state = 32'd61860;

function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// Upper LCG bits, the low ones repeat too quickly
function automatic int pick_below(input int unsigned n);
    return int'((lcg_next() >> 16) % n);
endfunction

// Locked packet first, then whole queues from the highest priority down
function automatic xlist_t expected_order(input xlist_t loaded, input int lock_prio);
    xlist_t res;
    bit     taken [$];
    bit     lock_done;
    lock_done = (lock_prio < 0);
    foreach (loaded[i]) begin
        taken.push_back(1'b0);
        if (!lock_done && int'(loaded[i].prio) == lock_prio) begin
            res.push_back(loaded[i]);
            taken[i]  = 1'b1;
            lock_done = loaded[i].last;
        end
    end
    for (int p = QUEUES_PER_PORT - 1; p >= 0; p--) begin
        foreach (loaded[i]) begin
            if (!taken[i] && int'(loaded[i].prio) == p) begin
                res.push_back(loaded[i]);
            end
        end
    end
    return res;
endfunction

task automatic check_eq(input logic [63:0] got, input logic [63:0] want, input string what);
    if (got !== want) begin
        abort_run($sformatf("[ERROR] %0t: %s mismatch, got 0x%0h, expected 0x%0h",
                            $time, what, got, want));
    end
endtask

`endif

// File: verification/pkt_egress_tb.sv
/* Testbench for the egress top level with clock, reset, Wishbone host driver,
   output monitor, stream compare and the test sequence */
module pkt_egress_tb;

    import router_cfg_pkg::*;
    import pkt_fmt_pkg::*;

    localparam int NUM_EGR_PORTS = 4;
    localparam int ACK_TIMEOUT   = 200;
    localparam int DRAIN_TIMEOUT = 3000;

    logic       dequeue_req = 1'b0;
    logic       arst_n;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    wb_addr_t   wb_adr;
    word_t      wb_dat_w;
    word_t      wb_dat_r;
    logic       wb_ack;
    logic       out_valid;
    word_t      out_data;
    logic       out_last;
    logic [1:0] out_port;
    prio_t      out_queue;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    `include "pkt_egress_ref.svh"

    xword_t obs_q    [NUM_EGR_PORTS][$];
    xword_t expect_q [NUM_EGR_PORTS][$];
    xword_t load_log [NUM_EGR_PORTS][$];
    int     seen_cnt [NUM_EGR_PORTS] = '{default: 0};
    logic   in_pkt   [NUM_EGR_PORTS] = '{default: 1'b0};
    prio_t  cur_q    [NUM_EGR_PORTS];

    pkt_egress_top #(.NUM_EGR_PORTS(NUM_EGR_PORTS)) u_pkt_egress_top (
        .dequeue_req (dequeue_req),
        .arst_n      (arst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_last    (out_last),
        .out_port    (out_port),
        .out_queue   (out_queue)
    );

    always #5 dequeue_req = ~dequeue_req;

    ////////////////////////////////////////////////////////////
    // Output monitor and stream compare
    ////////////////////////////////////////////////////////////

    // Outputs settle after the rising edge, so sample on the falling one
    always @(negedge dequeue_req) begin : monitor
        xword_t w;
        if (arst_n && out_valid) begin
            if (in_pkt[out_port]) begin
                check_eq(64'(out_queue), 64'(cur_q[out_port]),
                         $sformatf("queue inside packet on port %0d", out_port));
            end
            w = xword_t'({out_queue, out_last, out_data});
            obs_q[out_port].push_back(w);
            seen_cnt[out_port]++;
            in_pkt[out_port] = !out_last;
            cur_q[out_port]  = out_queue;
        end
    end

    always @(posedge dequeue_req) begin : compare
        xword_t got;
        xword_t want;
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            while (obs_q[p].size() > 0 && expect_q[p].size() > 0) begin
                got  = obs_q[p].pop_front();
                want = expect_q[p].pop_front();
                check_eq(64'(got.data), 64'(want.data), $sformatf("port %0d data", p));
                check_eq(64'(got.prio), 64'(want.prio), $sformatf("port %0d queue", p));
                check_eq(64'(got.last), 64'(want.last), $sformatf("port %0d last", p));
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Wishbone host driver
    ////////////////////////////////////////////////////////////

    task automatic bus_cycle(input logic we, input logic last, input int q, input word_t data);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = wb_addr_t'(q);
        wb_adr[LAST_BIT] = last;
        wb_dat_w = data;
        do begin
            @(posedge dequeue_req);
            #1;
            waited++;
            if (!wb_ack && waited > ACK_TIMEOUT) begin
                abort_run($sformatf("Timeout: no Wishbone ack for queue %0d", q));
            end
        end while (!wb_ack);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic send_word(input int p, input int prio, input logic last, input word_t data);
        load_log[p].push_back(xword_t'({prio_t'(prio), last, data}));
        bus_cycle(1'b1, last, p * QUEUES_PER_PORT + prio, data);
    endtask

    task automatic send_packet(input int p, input int prio, input int len, input bit close);
        for (int i = 0; i < len; i++) begin
            send_word(p, prio, close && (i == len - 1), lcg_next());
        end
    endtask

    task automatic read_level(input int q, input int want);
        bus_cycle(1'b0, 1'b0, q, '0);
        check_eq(64'(wb_dat_r), 64'(want), $sformatf("occupancy of queue %0d", q));
    endtask

    ////////////////////////////////////////////////////////////
    // Scenario helpers
    ////////////////////////////////////////////////////////////

    task automatic wait_seen(input int p, input int target);
        int waited;
        waited = 0;
        while (seen_cnt[p] < target) begin
            @(posedge dequeue_req);
            #1;
            waited++;
            if (seen_cnt[p] < target && waited > DRAIN_TIMEOUT) begin
                abort_run($sformatf("Timeout: port %0d sent only %0d of %0d words",
                                    p, seen_cnt[p], target));
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        bit busy;
        waited = 0;
        busy   = 1'b1;
        while (busy) begin
            @(posedge dequeue_req);
            #1;
            waited++;
            busy = 1'b0;
            for (int p = 0; p < NUM_EGR_PORTS; p++) begin
                if (expect_q[p].size() != 0 || obs_q[p].size() != 0) begin
                    busy = 1'b1;
                end
            end
            if (busy && waited > DRAIN_TIMEOUT) begin
                abort_run("Timeout: egress output stalled before all expected words came out");
            end
        end
    endtask

    task automatic commit_port(input int p, input int lock_prio);
        xlist_t order;
        order = expected_order(load_log[p], lock_prio);
        foreach (order[i]) begin
            expect_q[p].push_back(order[i]);
        end
        load_log[p].delete();
    endtask

    // Open a packet without its last word so the port stays locked
    task automatic lock_port(input int p, input int prio, input int n);
        int base;
        base = seen_cnt[p];
        send_packet(p, prio, n, 1'b0);
        wait_seen(p, base + n);
    endtask

    task automatic load_other_queues(input int p, input int lock_prio);
        int npkt;
        for (int q = 0; q < QUEUES_PER_PORT; q++) begin
            if (q != lock_prio) begin
                npkt = 1 + pick_below(2);
                for (int k = 0; k < npkt; k++) begin
                    send_packet(p, q, 1 + pick_below(4), 1'b1);
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int base;
        int lock_q [NUM_EGR_PORTS];
        arst_n   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (4) @(posedge dequeue_req);
        #1;
        arst_n = 1'b1;
        check_eq(64'(out_valid), 64'd0, "out_valid after reset");
        check_eq(64'(wb_ack), 64'd0, "wb_ack after reset");

        // Single 5-word packet on port 2, queue 1
        send_packet(2, 1, 5, 1'b1);
        commit_port(2, -1);
        wait_drain();

        // Strict priority behind a locked queue 0 on port 0
        lock_port(0, 0, 3);
        send_packet(0, 1, 2, 1'b1);
        send_packet(0, 3, 4, 1'b1);
        send_packet(0, 1, 3, 1'b1);
        send_packet(0, 3, 2, 1'b1);
        send_word(0, 0, 1'b1, lcg_next());
        commit_port(0, 0);
        wait_drain();

        // Random packets on every queue of port 3
        lock_q[3] = pick_below(QUEUES_PER_PORT);
        lock_port(3, lock_q[3], 1 + pick_below(3));
        load_other_queues(3, lock_q[3]);
        send_word(3, lock_q[3], 1'b1, lcg_next());
        commit_port(3, lock_q[3]);
        wait_drain();

        // All ports loaded at once
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            lock_q[p] = pick_below(QUEUES_PER_PORT);
            lock_port(p, lock_q[p], 1);
        end
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            load_other_queues(p, lock_q[p]);
        end
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            send_word(p, lock_q[p], 1'b1, lcg_next());
            commit_port(p, lock_q[p]);
        end
        wait_drain();

        // Fill queue 2 of port 1 while queue 1 holds the lock
        lock_port(1, 1, 2);
        send_packet(1, 2, 8, 1'b1);
        send_packet(1, 2, 8, 1'b1);
        read_level(6, 16);
        base = seen_cnt[1];
        send_word(1, 1, 1'b1, lcg_next());
        // Extra word only fits once the queue 2 head has left
        send_word(1, 2, 1'b1, lcg_next());
        check_eq(64'(seen_cnt[1] >= base + 2), 64'd1, "pop before ack of write to full queue");
        commit_port(1, 1);
        wait_drain();
        read_level(6, 0);
        read_level(5, 0);

        $display("Test OK");
        $finish;
    end

endmodule : pkt_egress_tb

// File: pkt_egress_top.f
+incdir+verification
design/router_cfg_pkg.sv
design/pkt_fmt_pkg.sv
design/queue_buffer.sv
design/egress_scheduler.sv
design/dequeue_engine.sv
design/pkt_egress_top.sv
verification/pkt_egress_tb.sv

// File: Makefile
# Verilator build and run of the egress testbench

VERILATOR ?= verilator
TOP       ?= pkt_egress_tb
FILELIST  ?= pkt_egress_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= Test OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verification/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the output
run: $(BIN)
	@out="$$($(abspath $(BIN)))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
